/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and greps the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_cpu -f sources.f > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_cpu > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; } \
  || { echo "simulation passed"; exit 0; }

/* sim/cpu_assert.sv */
// concurrent checks on the core, bound into the cpu top level by the testbench build
`timescale 1ns/1ps

module cpu_assert (
  input logic              clk,
  input logic              rst_n,
  input cpu_pkg::xlen_t    pc,
  input logic              halted,
  input logic              illegal,
  input logic              reg_wen_o,
  input cpu_pkg::reg_idx_t rd_o
);

  // fetch address stays on a word boundary
  a_pc_align: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
    else $error("pc not word aligned");

  // x0 is never reported as written
  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n) reg_wen_o |-> rd_o != '0)
    else $error("register write to x0 retired");

  // halt or illegal holds the pc
  a_freeze: assert property (@(posedge clk) disable iff (!rst_n)
    (halted || illegal) |=> $stable(pc))
    else $error("pc moved while frozen");

endmodule

bind cpu cpu_assert u_cpu_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .pc        (pc),
  .halted    (halted),
  .illegal   (illegal),
  .reg_wen_o (reg_wen_o),
  .rd_o      (rd_o)
);

/* sim/tb_cpu.sv */
// self-checking testbench of the rv64 core, loads generated programs and compares with a model
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_cpu;
  import cpu_pkg::*;

  localparam int num_progs = 5;
  localparam int freeze_cycles = 10;
  localparam int iaw = $clog2(`IMEM_DEPTH);
  localparam int op_lui = 'h37;
  localparam int op_auipc = 'h17;
  localparam int op_jalr = 'h67;
  localparam int op_load = 'h03;
  localparam int op_imm = 'h13;
  localparam inst_t ebreak_inst = 32'h0010_0073;
  // ecall is outside the supported subset
  localparam inst_t ecall_inst = 32'h0000_0073;

  logic           clk;
  logic           rst_n;
  logic           imem_we;
  logic [iaw-1:0] imem_addr;
  inst_t          imem_wdata;
  xlen_t          pc;
  inst_t          inst;
  logic           halted;
  logic           illegal;
  logic           reg_wen_o;
  reg_idx_t       rd_o;
  xlen_t          reg_wdata_o;

  // all programs back to back, prog_start marks each one
  inst_t prog_q [$];
  int    prog_start [num_progs+1];

  // architectural state of the model
  inst_t      model_imem [`IMEM_DEPTH];
  xlen_t      model_rf [32];
  logic [7:0] model_bytes [8*`DMEM_DEPTH];
  xlen_t      model_pc;

  logic     armed;
  logic     done;
  int       frozen;
  int       run_cycles;
  int       cycle_limit;
  inst_t    cur_inst;
  logic     exp_wen;
  reg_idx_t exp_rd;
  xlen_t    exp_wdata;
  logic     exp_halt;
  logic     exp_ill;

  cpu dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_we     (imem_we),
    .imem_addr   (imem_addr),
    .imem_wdata  (imem_wdata),
    .pc          (pc),
    .inst        (inst),
    .halted      (halted),
    .illegal     (illegal),
    .reg_wen_o   (reg_wen_o),
    .rd_o        (rd_o),
    .reg_wdata_o (reg_wdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_xlen(string name, xlen_t exp, xlen_t act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_inst(string name, inst_t exp, inst_t act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_idx(string name, reg_idx_t exp, reg_idx_t act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  // instruction encoders
  function automatic inst_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
  endfunction

  function automatic inst_t enc_i(int imm, int rs1, int f3, int rd, int op);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'(op)};
  endfunction

  function automatic inst_t enc_s(int imm, int rs2, int rs1, int f3);
    logic [11:0] s;
    s = 12'(imm);
    return {s[11:5], 5'(rs2), 5'(rs1), 3'(f3), s[4:0], 7'b0100011};
  endfunction

  function automatic inst_t enc_b(int off, int rs2, int rs1, int f3);
    logic [12:0] b;
    b = 13'(off);
    return {b[12], b[10:5], 5'(rs2), 5'(rs1), 3'(f3), b[4:1], b[11], 7'b1100011};
  endfunction

  function automatic inst_t enc_u(int imm, int rd, int op);
    return {20'(imm), 5'(rd), 7'(op)};
  endfunction

  function automatic inst_t enc_j(int off, int rd);
    logic [20:0] j;
    j = 21'(off);
    return {j[20], j[10:1], j[11], j[19:12], 5'(rd), 7'b1101111};
  endfunction

  task automatic emit(inst_t w);
    prog_q.push_back(w);
  endtask

  // lui plus addi, the +0x800 undoes the sign of the low part
  task automatic load_const(int rd, int val);
    emit(enc_u((val + 'h800) >>> 12, rd, op_lui));
    emit(enc_i(val, rd, 0, rd, op_imm));
  endtask

  function automatic inst_t random_alu_inst();
    int rd;
    int rs1;
    int rs2;
    int f3;
    int f7;
    rd = $urandom_range(0, 15);
    rs1 = $urandom_range(0, 15);
    rs2 = $urandom_range(0, 15);
    f3 = $urandom_range(0, 7);
    if ($urandom_range(0, 1) == 0) begin
      // shifts take a six bit amount, srai sets bit 30
      if (f3 == 1) return enc_i($urandom_range(0, 63), rs1, f3, rd, op_imm);
      if (f3 == 5) begin
        return enc_i($urandom_range(0, 63) + 'h400 * $urandom_range(0, 1), rs1, f3, rd, op_imm);
      end
      return enc_i($urandom, rs1, f3, rd, op_imm);
    end
    f7 = ((f3 == 0 || f3 == 5) && $urandom_range(0, 1) == 1) ? 'h20 : 0;
    return enc_r(f7, rs2, rs1, f3, rd);
  endfunction

  task automatic build_programs();
    int off;
    int size;
    int v;
    // alu mix
    prog_start[0] = prog_q.size();
    for (int r = 1; r < 16; r++) load_const(r, $urandom);
    for (int k = 0; k < 40; k++) emit(random_alu_inst());
    emit(ebreak_inst);
    // stores of every width then all seven loads from the same doubleword
    prog_start[1] = prog_q.size();
    load_const(10, 1024);
    for (int r = 5; r < 9; r++) load_const(r, $urandom);
    emit(enc_i(32, 5, 1, 9, op_imm));
    emit(enc_r(0, 6, 9, 6, 9));
    for (int k = 0; k < 6; k++) begin
      off = 8 * $urandom_range(0, 127);
      emit(enc_s(off, 9, 10, 3));
      emit(enc_s(off + 4 * $urandom_range(0, 1), 7, 10, 2));
      emit(enc_s(off + 2 * $urandom_range(0, 3), 8, 10, 1));
      emit(enc_s(off + $urandom_range(0, 7), 5, 10, 0));
      for (int f3 = 0; f3 < 7; f3++) begin
        size = 1 << (f3 % 4);
        emit(enc_i(off + size * $urandom_range(0, 8 / size - 1), 10, f3, 11 + f3, op_load));
      end
    end
    emit(ebreak_inst);
    // six branch conditions, taken ones skip the counter increment
    prog_start[2] = prog_q.size();
    for (int k = 0; k < 4; k++) begin
      v = $urandom;
      load_const(1, v);
      load_const(2, (k == 0) ? v : int'($urandom));
      for (int f3 = 0; f3 < 8; f3++) begin
        if (f3 != 2 && f3 != 3) begin
          emit(enc_b(8, 2, 1, f3));
          emit(enc_i(1, 3, 0, 3, op_imm));
        end
      end
    end
    emit(enc_j(8, 4));
    emit(enc_i(1, 3, 0, 3, op_imm));
    // odd jalr targets, bit 0 dropped
    emit(enc_u(0, 5, op_auipc));
    emit(enc_i(17, 5, 0, 5, op_imm));
    emit(enc_i(0, 5, 0, 6, op_jalr));
    emit(enc_i(1, 3, 0, 3, op_imm));
    emit(enc_u(0, 5, op_auipc));
    emit(enc_i(13, 5, 0, 7, op_jalr));
    emit(enc_i(1, 3, 0, 3, op_imm));
    emit(ebreak_inst);
    // upper immediates
    prog_start[3] = prog_q.size();
    for (int k = 0; k < 8; k++) begin
      emit(enc_u($urandom, $urandom_range(1, 31), op_lui));
      emit(enc_u($urandom, $urandom_range(1, 31), op_auipc));
    end
    emit(ebreak_inst);
    // ends on an unsupported encoding
    prog_start[4] = prog_q.size();
    load_const(1, $urandom);
    emit(ecall_inst);
    prog_start[5] = prog_q.size();
  endtask

  function automatic logic take_branch(logic [2:0] f3, xlen_t a, xlen_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic xlen_t alu_ref(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[5:0];
      3'b010:  return xlen_t'($signed(a) < $signed(b));
      3'b011:  return xlen_t'(a < b);
      3'b100:  return a ^ b;
      3'b101:  return alt ? xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // little endian bytes, extension from the top loaded bit
  function automatic xlen_t load_value(xlen_t addr, logic [2:0] f3);
    xlen_t v;
    int    size;
    int    base;
    size = 1 << f3[1:0];
    base = int'(addr[11:0]);
    v = '0;
    for (int i = size - 1; i >= 0; i--) v = (v << 8) | xlen_t'(model_bytes[base + i]);
    if (!f3[2] && size < 8 && v[size*8-1]) v = v | (~xlen_t'(0) << (size * 8));
    return v;
  endfunction

  function automatic void store_value(xlen_t addr, xlen_t data, logic [2:0] f3);
    int size;
    int base;
    size = 1 << f3[1:0];
    base = int'(addr[11:0]);
    for (int i = 0; i < size; i++) model_bytes[base + i] = data[i*8 +: 8];
  endfunction

  // one instruction of the reference model, returns what should retire
  function automatic void iss_step(input inst_t word, output logic wen, output reg_idx_t rd,
                                   output xlen_t wd, output logic hlt, output logic ill);
    xlen_t      a;
    xlen_t      b;
    xlen_t      immi;
    xlen_t      res;
    xlen_t      npc;
    logic [2:0] f3;
    logic       w;
    f3 = word[14:12];
    a = model_rf[word[19:15]];
    b = model_rf[word[24:20]];
    immi = {{52{word[31]}}, word[31:20]};
    npc = model_pc + 64'd4;
    res = '0;
    w = 1'b0;
    hlt = 1'b0;
    ill = 1'b0;
    case (word[6:0])
      7'h37: begin
        res = {{32{word[31]}}, word[31:12], 12'b0};
        w = 1'b1;
      end
      7'h17: begin
        res = model_pc + {{32{word[31]}}, word[31:12], 12'b0};
        w = 1'b1;
      end
      7'h6f: begin
        res = model_pc + 64'd4;
        npc = (model_pc + {{43{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0})
              & ~64'd1;
        w = 1'b1;
      end
      7'h67: begin
        res = model_pc + 64'd4;
        npc = (a + immi) & ~64'd1;
        w = 1'b1;
      end
      7'h63: begin
        if (take_branch(f3, a, b)) begin
          npc = model_pc + {{51{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
        end
      end
      7'h03: begin
        res = load_value(a + immi, f3);
        w = 1'b1;
      end
      7'h23: store_value(a + {{52{word[31]}}, word[31:25], word[11:7]}, b, f3);
      7'h13: begin
        res = alu_ref(f3, word[30] && f3 == 3'b101, a, immi);
        w = 1'b1;
      end
      7'h33: begin
        res = alu_ref(f3, word[30], a, b);
        w = 1'b1;
      end
      7'h73: begin
        hlt = (word == ebreak_inst);
        ill = (word != ebreak_inst);
      end
      default: ill = 1'b1;
    endcase
    // frozen core keeps its pc
    if (hlt || ill) npc = model_pc;
    rd = word[11:7];
    wd = res;
    wen = w && (word[11:7] != 5'd0);
    if (wen) model_rf[word[11:7]] = res;
    model_pc = npc;
  endfunction

  // load during reset, arm the model, release reset and wait for the freeze
  task automatic run_program(int p);
    int len;
    int reset_cycles;
    len = prog_start[p+1] - prog_start[p];
    reset_cycles = (len > 16) ? len : 16;
    @(negedge clk);
    rst_n = 1'b0;
    for (int i = 0; i < reset_cycles; i++) begin
      imem_we = (i < len);
      if (i < len) begin
        imem_addr = iaw'(i);
        imem_wdata = prog_q[prog_start[p] + i];
        model_imem[i] = prog_q[prog_start[p] + i];
      end
      @(negedge clk);
    end
    imem_we = 1'b0;
    @(posedge clk);
    for (int r = 0; r < 32; r++) model_rf[r] = '0;
    model_pc = `PC_RST;
    frozen = 0;
    done = 1'b0;
    armed = 1'b1;
    @(negedge clk);
    rst_n = 1'b1;
    wait (done == 1'b1);
  endtask

  // compare process
  always @(negedge clk) begin
    if (armed) begin
      cur_inst = model_imem[model_pc[iaw+1:2]];
      check_xlen("pc", model_pc, pc);
      check_inst("inst", cur_inst, inst);
      iss_step(cur_inst, exp_wen, exp_rd, exp_wdata, exp_halt, exp_ill);
      check_bit("halted", exp_halt, halted);
      check_bit("illegal", exp_ill, illegal);
      check_bit("reg_wen_o", exp_wen, reg_wen_o);
      check_idx("rd_o", exp_rd, rd_o);
      if (exp_wen) check_xlen("reg_wdata_o", exp_wdata, reg_wdata_o);
      if (exp_halt || exp_ill) begin
        frozen++;
        if (frozen > freeze_cycles) begin
          armed = 1'b0;
          done = 1'b1;
        end
      end
    end
  end

  // counts only cycles where a program runs
  always @(posedge clk) begin
    if (armed) begin
      run_cycles++;
      if (run_cycles > cycle_limit) begin
        $display("timeout, programs did not finish within %0d cycles", cycle_limit);
        abort_run();
      end
    end
  end

  initial begin
    void'($urandom(68));
    rst_n = 1'b0;
    imem_we = 1'b0;
    imem_addr = '0;
    imem_wdata = '0;
    armed = 1'b0;
    done = 1'b0;
    frozen = 0;
    run_cycles = 0;
    model_pc = `PC_RST;
    build_programs();
    cycle_limit = prog_q.size() + 64;
    for (int p = 0; p < num_progs; p++) run_program(p);
    $display("TEST OK");
    $finish;
  end

endmodule

/* sources.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/inst_mem.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/data_mem.sv
verilog/cpu.sv
sim/cpu_assert.sv
sim/tb_cpu.sv

/* verilog/alu.sv */
// combinational alu of the core, covers integer ops, shifts and branch compares
`timescale 1ns/1ps

module alu (
  input  cpu_pkg::xlen_t   operand_1,
  input  cpu_pkg::xlen_t   operand_2,
  input  cpu_pkg::alu_op_e alu_op,
  output cpu_pkg::xlen_t   alu_result
);
  import cpu_pkg::*;

  logic [5:0] shamt;
  logic       lt_s;
  logic       lt_u;

  // rv64 shifts use six bits
  assign shamt = operand_2[5:0];
  assign lt_s  = $signed(operand_1) < $signed(operand_2);
  assign lt_u  = operand_1 < operand_2;

  always_comb begin
    case (alu_op)
      alu_add:    alu_result = operand_1 + operand_2;
      alu_sub:    alu_result = operand_1 - operand_2;
      alu_sll:    alu_result = operand_1 << shamt;
      alu_srl:    alu_result = operand_1 >> shamt;
      alu_sra:    alu_result = xlen_t'($signed(operand_1) >>> shamt);
      alu_xor:    alu_result = operand_1 ^ operand_2;
      alu_or:     alu_result = operand_1 | operand_2;
      alu_and:    alu_result = operand_1 & operand_2;
      // set-less-than and branch compares, result in bit 0
      alu_slt:    alu_result = xlen_t'(lt_s);
      alu_sltu:   alu_result = xlen_t'(lt_u);
      alu_lt:     alu_result = xlen_t'(lt_s);
      alu_ltu:    alu_result = xlen_t'(lt_u);
      alu_ge:     alu_result = xlen_t'(!lt_s);
      alu_geu:    alu_result = xlen_t'(!lt_u);
      alu_eq:     alu_result = xlen_t'(operand_1 == operand_2);
      alu_ne:     alu_result = xlen_t'(operand_1 != operand_2);
      // lui
      alu_pass_b: alu_result = operand_2;
      default:    alu_result = '0;
    endcase
  end

endmodule

/* verilog/cpu.sv */
// top of the single-cycle rv64 core, ties fetch, decode, execute, memory and the pc together
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           imem_we,
  input  logic [$clog2(`IMEM_DEPTH)-1:0] imem_addr,
  input  cpu_pkg::inst_t                 imem_wdata,
  output cpu_pkg::xlen_t                 pc,
  output cpu_pkg::inst_t                 inst,
  output logic                           halted,
  output logic                           illegal,
  output logic                           reg_wen_o,
  output cpu_pkg::reg_idx_t              rd_o,
  output cpu_pkg::xlen_t                 reg_wdata_o
);
  import cpu_pkg::*;

  // decode outputs
  reg_idx_t   rd;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  xlen_t      imm;
  alu_op_e    alu_op;
  mem_width_e mem_width;
  logic       need_imm;
  logic       is_auipc;
  logic       is_jal;
  logic       is_jalr;
  logic       is_branch;
  logic       is_load;
  logic       reg_wen;
  logic       mem_wen;
  logic       is_unsigned;
  logic       is_ebreak;

  // datapath
  xlen_t      rdata_1;
  xlen_t      rdata_2;
  xlen_t      operand_1;
  xlen_t      operand_2;
  xlen_t      alu_result;
  xlen_t      load_data;
  xlen_t      reg_wdata;
  xlen_t      pc_plus4;
  xlen_t      next_pc;
  logic       freeze;
  logic       mem_wen_q;

  inst_mem u_inst_mem (
    .clk        (clk),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .pc         (pc),
    .inst       (inst)
  );

  decoder u_decoder (
    .inst        (inst),
    .rd          (rd),
    .rs1         (rs1),
    .rs2         (rs2),
    .imm         (imm),
    .alu_op      (alu_op),
    .need_imm    (need_imm),
    .is_auipc    (is_auipc),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .is_branch   (is_branch),
    .is_load     (is_load),
    .reg_wen     (reg_wen),
    .mem_wen     (mem_wen),
    .is_unsigned (is_unsigned),
    .is_ebreak   (is_ebreak),
    .illegal     (illegal),
    .mem_width   (mem_width)
  );

  // ebreak or a bad encoding stops the core until reset
  assign halted = is_ebreak;
  assign freeze = halted | illegal;

  // writes only retire when the core is running, never to x0
  assign reg_wen_o = reg_wen & ~freeze & (rd != '0);
  assign mem_wen_q = mem_wen & ~freeze;

  regfile u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .reg_wen   (reg_wen_o),
    .reg_wdata (reg_wdata),
    .rdata_1   (rdata_1),
    .rdata_2   (rdata_2)
  );

  // pc feeds the adder for auipc and jal targets
  assign operand_1 = (is_auipc | is_jal) ? pc : rdata_1;
  assign operand_2 = need_imm ? imm : rdata_2;

  alu u_alu (
    .operand_1  (operand_1),
    .operand_2  (operand_2),
    .alu_op     (alu_op),
    .alu_result (alu_result)
  );

  // alu result is the effective address
  data_mem u_data_mem (
    .clk         (clk),
    .addr        (alu_result),
    .wdata       (rdata_2),
    .mem_wen     (mem_wen_q),
    .mem_ren     (is_load),
    .mem_width   (mem_width),
    .is_unsigned (is_unsigned),
    .load_data   (load_data)
  );

  assign pc_plus4 = pc + xlen_t'(4);

  // link address, load value or alu result
  always_comb begin
    if (is_jal || is_jalr) begin
      reg_wdata = pc_plus4;
    end else if (is_load) begin
      reg_wdata = load_data;
    end else begin
      reg_wdata = alu_result;
    end
  end

  // jump targets lose bit 0, a taken branch adds the b immediate
  always_comb begin
    if (is_jal || is_jalr) begin
      next_pc = alu_result & ~xlen_t'(1);
    end else if (is_branch && (alu_result == xlen_t'(1))) begin
      next_pc = pc + imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= `PC_RST;
    end else if (!freeze) begin
      pc <= next_pc;
    end
  end

  // retire view for the testbench
  assign rd_o        = rd;
  assign reg_wdata_o = reg_wdata;

endmodule

/* verilog/cpu_defs.svh */
// widths, memory depths and reset pc for the rv64 core, included by the package and the rtl
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// register and data path width
`define XLEN 64

// instruction word width, no compressed encodings
`define ILEN 32

// five bits address x0..x31
`define REG_IDX_W 5

// program store, one 32-bit word per entry
`define IMEM_DEPTH 256

// data store, one doubleword per entry
`define DMEM_DEPTH 512

// first fetch address after reset
`define PC_RST 64'h0

`endif

/* verilog/cpu_pkg.sv */
// shared data types of the rv64 core, imported by every rtl block and by the testbench
`include "cpu_defs.svh"

package cpu_pkg;

  // architectural words
  typedef logic [`XLEN-1:0]      xlen_t;
  typedef logic [`ILEN-1:0]      inst_t;
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;

  // alu operations
  // compare ops give 0 or 1 in bit 0, the top uses it as branch taken
  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_eq,
    alu_ne,
    alu_lt,
    alu_ge,
    alu_ltu,
    alu_geu,
    // lui result is just the immediate
    alu_pass_b
  } alu_op_e;

  // access size, same code as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    mem_byte  = 2'b00,
    mem_half  = 2'b01,
    mem_word  = 2'b10,
    mem_dword = 2'b11
  } mem_width_e;

endpackage

/* verilog/data_mem.sv */
// data memory of the core, byte-lane stores and sign or zero extended loads in one cycle
`timescale 1ns/1ps
`include "cpu_defs.svh"

module data_mem (
  input  logic                clk,
  input  cpu_pkg::xlen_t      addr,
  input  cpu_pkg::xlen_t      wdata,
  input  logic                mem_wen,
  input  logic                mem_ren,
  input  cpu_pkg::mem_width_e mem_width,
  input  logic                is_unsigned,
  output cpu_pkg::xlen_t      load_data
);
  import cpu_pkg::*;

  localparam int idx_w = $clog2(`DMEM_DEPTH);

  xlen_t            mem [`DMEM_DEPTH];
  logic [idx_w-1:0] idx;
  logic [2:0]       offset;
  logic [7:0]       lane_mask;
  xlen_t            wdata_shift;
  xlen_t            rdata_shift;

  // doubleword row and byte within it
  assign idx    = addr[idx_w+2:3];
  assign offset = addr[2:0];

  // lanes touched by the access, accesses stay inside one row
  always_comb begin
    case (mem_width)
      mem_byte: lane_mask = 8'h01 << offset;
      mem_half: lane_mask = 8'h03 << offset;
      mem_word: lane_mask = 8'h0f << offset;
      default:  lane_mask = 8'hff;
    endcase
  end

  // move store data up to its lanes
  assign wdata_shift = wdata << {offset, 3'b000};

  always_ff @(posedge clk) begin
    if (mem_wen) begin
      for (int i = 0; i < 8; i++) begin
        if (lane_mask[i]) begin
          mem[idx][i*8 +: 8] <= wdata_shift[i*8 +: 8];
        end
      end
    end
  end

  // addressed byte down to lane 0
  assign rdata_shift = mem[idx] >> {offset, 3'b000};

  always_comb begin
    if (!mem_ren) begin
      load_data = '0;
    end else begin
      case (mem_width)
        mem_byte: load_data = {{(`XLEN-8){~is_unsigned & rdata_shift[7]}}, rdata_shift[7:0]};
        mem_half: load_data = {{(`XLEN-16){~is_unsigned & rdata_shift[15]}}, rdata_shift[15:0]};
        mem_word: load_data = {{(`XLEN-32){~is_unsigned & rdata_shift[31]}}, rdata_shift[31:0]};
        default:  load_data = rdata_shift;
      endcase
    end
  end

endmodule

/* verilog/decoder.sv */
// instruction decoder of the core, turns one rv64 instruction into indices, immediate and controls
`timescale 1ns/1ps
`include "cpu_defs.svh"

module decoder (
  input  cpu_pkg::inst_t      inst,
  output cpu_pkg::reg_idx_t   rd,
  output cpu_pkg::reg_idx_t   rs1,
  output cpu_pkg::reg_idx_t   rs2,
  output cpu_pkg::xlen_t      imm,
  output cpu_pkg::alu_op_e    alu_op,
  output logic                need_imm,
  output logic                is_auipc,
  output logic                is_jal,
  output logic                is_jalr,
  output logic                is_branch,
  output logic                is_load,
  output logic                reg_wen,
  output logic                mem_wen,
  output logic                is_unsigned,
  output logic                is_ebreak,
  output logic                illegal,
  output cpu_pkg::mem_width_e mem_width
);
  import cpu_pkg::*;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;
  localparam inst_t      ebreak_enc = 32'h0010_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  logic       wr_reg;
  logic       wr_mem;
  logic       bad;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  // sign extended immediates, one per format
  assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    imm         = '0;
    alu_op      = alu_add;
    need_imm    = 1'b0;
    is_auipc    = 1'b0;
    is_jal      = 1'b0;
    is_jalr     = 1'b0;
    is_branch   = 1'b0;
    is_load     = 1'b0;
    is_ebreak   = 1'b0;
    wr_reg      = 1'b0;
    wr_mem      = 1'b0;
    bad         = 1'b0;
    // size and extension come straight from funct3
    mem_width   = mem_width_e'(funct3[1:0]);
    is_unsigned = funct3[2];
    case (opcode)
      op_lui: begin
        imm      = imm_u;
        alu_op   = alu_pass_b;
        need_imm = 1'b1;
        wr_reg   = 1'b1;
      end
      op_auipc: begin
        imm      = imm_u;
        need_imm = 1'b1;
        is_auipc = 1'b1;
        wr_reg   = 1'b1;
      end
      // target pc+imm computed by the alu
      op_jal: begin
        imm      = imm_j;
        need_imm = 1'b1;
        is_jal   = 1'b1;
        wr_reg   = 1'b1;
      end
      op_jalr: begin
        imm      = imm_i;
        need_imm = 1'b1;
        is_jalr  = 1'b1;
        wr_reg   = 1'b1;
        bad      = (funct3 != 3'b000);
      end
      // alu compares rs1 and rs2, imm goes to the pc adder
      op_branch: begin
        imm       = imm_b;
        is_branch = 1'b1;
        case (funct3)
          3'b000:  alu_op = alu_eq;
          3'b001:  alu_op = alu_ne;
          3'b100:  alu_op = alu_lt;
          3'b101:  alu_op = alu_ge;
          3'b110:  alu_op = alu_ltu;
          3'b111:  alu_op = alu_geu;
          default: bad = 1'b1;
        endcase
      end
      // no ldu in rv64
      op_load: begin
        imm      = imm_i;
        need_imm = 1'b1;
        is_load  = 1'b1;
        wr_reg   = 1'b1;
        bad      = (funct3 == 3'b111);
      end
      op_store: begin
        imm      = imm_s;
        need_imm = 1'b1;
        wr_mem   = 1'b1;
        bad      = funct3[2];
      end
      op_imm: begin
        imm      = imm_i;
        need_imm = 1'b1;
        wr_reg   = 1'b1;
        case (funct3)
          3'b000:  alu_op = alu_add;
          3'b010:  alu_op = alu_slt;
          3'b011:  alu_op = alu_sltu;
          3'b100:  alu_op = alu_xor;
          3'b110:  alu_op = alu_or;
          3'b111:  alu_op = alu_and;
          // six bit shamt, funct6 above it
          3'b001: begin
            alu_op = alu_sll;
            bad    = (inst[31:26] != 6'b000000);
          end
          default: begin
            alu_op = inst[30] ? alu_sra : alu_srl;
            bad    = (inst[31] != 1'b0) || (inst[29:26] != 4'b0000);
          end
        endcase
      end
      op_reg: begin
        wr_reg = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_op = alu_add;
          {7'h20, 3'b000}: alu_op = alu_sub;
          {7'h00, 3'b001}: alu_op = alu_sll;
          {7'h00, 3'b010}: alu_op = alu_slt;
          {7'h00, 3'b011}: alu_op = alu_sltu;
          {7'h00, 3'b100}: alu_op = alu_xor;
          {7'h00, 3'b101}: alu_op = alu_srl;
          {7'h20, 3'b101}: alu_op = alu_sra;
          {7'h00, 3'b110}: alu_op = alu_or;
          {7'h00, 3'b111}: alu_op = alu_and;
          default:         bad = 1'b1;
        endcase
      end
      // ebreak is the only supported system op, ecall and csr ops are rejected
      op_system: begin
        is_ebreak = (inst == ebreak_enc);
        bad       = (inst != ebreak_enc);
      end
      default: bad = 1'b1;
    endcase
  end

  // an unsupported encoding never writes anything
  assign illegal = bad;
  assign reg_wen = wr_reg & ~bad;
  assign mem_wen = wr_mem & ~bad;

endmodule

/* verilog/inst_mem.sv */
// program store of the core, loaded by the testbench during reset and read combinationally by pc
`timescale 1ns/1ps
`include "cpu_defs.svh"

module inst_mem (
  input  logic                           clk,
  input  logic                           imem_we,
  input  logic [$clog2(`IMEM_DEPTH)-1:0] imem_addr,
  input  cpu_pkg::inst_t                 imem_wdata,
  input  cpu_pkg::xlen_t                 pc,
  output cpu_pkg::inst_t                 inst
);

  localparam int addr_w = $clog2(`IMEM_DEPTH);

  // one instruction per word, no reset on the array
  logic [`ILEN-1:0] mem [`IMEM_DEPTH];
  logic [addr_w-1:0] fetch_idx;

  // load port, strobed once per word
  always_ff @(posedge clk) begin
    if (imem_we) begin
      mem[imem_addr] <= imem_wdata;
    end
  end

  // word index, pc bits 1:0 are always zero
  assign fetch_idx = pc[addr_w+1:2];
  assign inst = mem[fetch_idx];

endmodule

/* verilog/regfile.sv */
// integer register file of the core, two combinational reads and one write per clock
`timescale 1ns/1ps
`include "cpu_defs.svh"

module regfile (
  input  logic              clk,
  input  logic              rst_n,
  input  cpu_pkg::reg_idx_t rs1,
  input  cpu_pkg::reg_idx_t rs2,
  input  cpu_pkg::reg_idx_t rd,
  input  logic              reg_wen,
  input  cpu_pkg::xlen_t    reg_wdata,
  output cpu_pkg::xlen_t    rdata_1,
  output cpu_pkg::xlen_t    rdata_2
);
  import cpu_pkg::*;

  localparam int num_regs = 1 << `REG_IDX_W;

  xlen_t regs [num_regs];

  // x0 is never written
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_wen && (rd != '0)) begin
      regs[rd] <= reg_wdata;
    end
  end

  // x0 reads as zero regardless of the array
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule
